//--- Makefile
VERILATOR  = verilator
TOP        = rvv_backend_tb
RTL_TOP    = rvv_backend
FILELIST   = src.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/rvv_config.svh
`ifndef RVV_CONFIG_SVH
`define RVV_CONFIG_SVH

// Vector register width in bits
`define VLEN 128

// Architectural vector registers
`define NUM_VREG 32

// Instructions offered per cycle by the scalar core
`define ISSUE_LANE 2

// Queue depths
`define CQ_DEPTH 4
`define UQ_DEPTH 4

`define VREG_IDX_W 5

`endif

//--- common/rvv_isa_pkg.sv
`include "rvv_config.svh"

package rvv_isa_pkg;

  // Vector-vector integer opcodes, RVV funct6 encoding
  typedef enum logic [5:0] {
    F6_VADD = 6'b000000,
    F6_VSUB = 6'b000010,
    F6_VAND = 6'b001001,
    F6_VOR  = 6'b001010,
    F6_VXOR = 6'b001011
  } funct6_e;

  // Selected element width, value 3 is reserved
  typedef enum logic [1:0] {
    SEW_E8  = 2'd0,
    SEW_E16 = 2'd1,
    SEW_E32 = 2'd2
  } sew_e;

  // Command word as issued by the scalar core
  // funct6 and vsew stay raw so illegal encodings can still be carried
  typedef struct packed {
    logic                   rsvd;
    logic [5:0]             funct6;
    logic [`VREG_IDX_W-1:0] vs2;
    logic [`VREG_IDX_W-1:0] vs1;
    logic [`VREG_IDX_W-1:0] vd;
    logic [1:0]             vsew;
  } rvv_cmd_t;

endpackage

//--- common/rvv_uop_pkg.sv
`include "rvv_config.svh"

package rvv_uop_pkg;

  typedef logic [`VREG_IDX_W-1:0] vreg_idx_t;

  // Operations executed by the ALU
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Decoded micro-op
  // sew is log2 of the element size in bytes, always 0 to 2 here
  typedef struct packed {
    alu_op_e    op;
    vreg_idx_t  vs2;
    vreg_idx_t  vs1;
    vreg_idx_t  vd;
    logic [1:0] sew;
  } rvv_uop_t;

endpackage

//--- design/multi_fifo.sv
`timescale 1ns/1ps

module multi_fifo #(
  parameter type T     = logic [7:0],
  parameter int  M     = 1,
  parameter int  N     = 1,
  parameter int  DEPTH = 4,
  localparam int AFW   = (M > 1) ? M - 1 : 1,
  localparam int AEW   = (N > 1) ? N - 1 : 1
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic [M-1:0]   push,
  input  T     [M-1:0]   datain,
  input  logic [N-1:0]   pop,
  output T     [N-1:0]   dataout,
  output logic           full,
  output logic [AFW-1:0] almost_full,
  output logic           empty,
  output logic [AEW-1:0] almost_empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [PW-1:0] wptr;
  logic [PW-1:0] rptr;
  logic [CW-1:0] count;
  logic [CW-1:0] free_cnt;
  logic [CW-1:0] push_cnt;
  logic [CW-1:0] pop_cnt;

  // Pointer step with wrap, DEPTH need not be a power of two
  function automatic logic [PW-1:0] ptr_add(input logic [PW-1:0] p, input int unsigned k);
    int unsigned sum;
    sum = (p + k) % DEPTH;
    return PW'(sum);
  endfunction

  // Push and pop patterns are contiguous from bit 0, so a count is enough
  always_comb begin
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < M; i++) begin
      push_cnt = push_cnt + CW'(push[i]);
    end
    for (int i = 0; i < N; i++) begin
      pop_cnt = pop_cnt + CW'(pop[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= ptr_add(wptr, push_cnt);
      rptr  <= ptr_add(rptr, pop_cnt);
      count <= count + push_cnt - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < M; i++) begin
      if (push[i]) begin
        mem[ptr_add(wptr, i)] <= datain[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      dataout[i] = mem[ptr_add(rptr, i)];
    end
  end

  assign free_cnt = CW'(DEPTH) - count;
  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);

  // Bit j flags exactly j+1 free slots, or j+1 stored entries
  always_comb begin
    for (int j = 0; j < AFW; j++) begin
      almost_full[j] = (free_cnt == CW'(j + 1));
    end
    for (int j = 0; j < AEW; j++) begin
      almost_empty[j] = (count == CW'(j + 1));
    end
  end

endmodule

//--- design/rvv_alu.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_alu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rvv_uop_pkg::rvv_uop_t  uop,
  input  logic                   uq_empty,
  output logic                   uq_pop,
  output rvv_uop_pkg::vreg_idx_t rd_idx_a,
  output rvv_uop_pkg::vreg_idx_t rd_idx_b,
  input  logic [`VLEN-1:0]       rd_data_a,
  input  logic [`VLEN-1:0]       rd_data_b,
  output logic                   wr_req,
  output rvv_uop_pkg::vreg_idx_t wr_vd,
  output logic [`VLEN-1:0]       wr_data,
  input  logic                   wr_gnt,
  output logic                   rt_valid,
  output rvv_uop_pkg::vreg_idx_t rt_vd,
  output logic [`VLEN-1:0]       rt_data
);

  import rvv_uop_pkg::*;

  localparam int VL = `VLEN;

  logic [VL-1:0] add_e8;
  logic [VL-1:0] add_e16;
  logic [VL-1:0] add_e32;
  logic [VL-1:0] sub_e8;
  logic [VL-1:0] sub_e16;
  logic [VL-1:0] sub_e32;
  logic [VL-1:0] sum;
  logic [VL-1:0] diff;
  logic          fire;

  assign rd_idx_a = uop.vs2;
  assign rd_idx_b = uop.vs1;

  // One slice per element, so carries and borrows stop at each boundary
  always_comb begin
    for (int i = 0; i < VL / 8; i++) begin
      add_e8[i*8 +: 8] = rd_data_a[i*8 +: 8] + rd_data_b[i*8 +: 8];
      sub_e8[i*8 +: 8] = rd_data_a[i*8 +: 8] - rd_data_b[i*8 +: 8];
    end
    for (int i = 0; i < VL / 16; i++) begin
      add_e16[i*16 +: 16] = rd_data_a[i*16 +: 16] + rd_data_b[i*16 +: 16];
      sub_e16[i*16 +: 16] = rd_data_a[i*16 +: 16] - rd_data_b[i*16 +: 16];
    end
    for (int i = 0; i < VL / 32; i++) begin
      add_e32[i*32 +: 32] = rd_data_a[i*32 +: 32] + rd_data_b[i*32 +: 32];
      sub_e32[i*32 +: 32] = rd_data_a[i*32 +: 32] - rd_data_b[i*32 +: 32];
    end
  end

  always_comb begin
    case (uop.sew)
      2'd0: begin
        sum  = add_e8;
        diff = sub_e8;
      end
      2'd1: begin
        sum  = add_e16;
        diff = sub_e16;
      end
      default: begin
        sum  = add_e32;
        diff = sub_e32;
      end
    endcase
  end

  always_comb begin
    case (uop.op)
      ALU_ADD: wr_data = sum;
      ALU_SUB: wr_data = diff;
      ALU_AND: wr_data = rd_data_a & rd_data_b;
      ALU_OR:  wr_data = rd_data_a | rd_data_b;
      ALU_XOR: wr_data = rd_data_a ^ rd_data_b;
      default: wr_data = '0;
    endcase
  end

  // Request held while the head waits for the write port
  assign wr_req = ~uq_empty;
  assign wr_vd  = uop.vd;
  assign fire   = wr_req & wr_gnt;
  assign uq_pop = fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rt_valid <= 1'b0;
    end else begin
      rt_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      rt_vd   <= wr_vd;
      rt_data <= wr_data;
    end
  end

endmodule

//--- design/rvv_backend.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [`ISSUE_LANE-1:0]                   insts_valid,
  input  rvv_isa_pkg::rvv_cmd_t [`ISSUE_LANE-1:0]  insts,
  output logic [`ISSUE_LANE-1:0]                   insts_ready,
  input  logic                                     load_valid,
  input  rvv_uop_pkg::vreg_idx_t                   load_vd,
  input  logic [`VLEN-1:0]                         load_data,
  output logic                                     load_ready,
  output logic                                     rt_valid,
  output rvv_uop_pkg::vreg_idx_t                   rt_vd,
  output logic [`VLEN-1:0]                         rt_data
);

  import rvv_isa_pkg::*;
  import rvv_uop_pkg::*;

  logic                     ready_en;
  logic                     cq_full;
  logic [`ISSUE_LANE-2:0]   cq_almost_full;
  rvv_cmd_t [0:0]           cq_head;
  logic                     cq_empty;
  logic                     cq_pop;
  logic                     uq_full;
  logic                     uq_push;
  rvv_uop_t [0:0]           dec_uop;
  rvv_uop_t [0:0]           uq_head;
  logic                     uq_empty;
  logic                     uq_pop;
  vreg_idx_t                rd_idx_a;
  vreg_idx_t                rd_idx_b;
  logic [`VLEN-1:0]         rd_data_a;
  logic [`VLEN-1:0]         rd_data_b;
  logic                     alu_wr_req;
  vreg_idx_t                alu_wr_vd;
  logic [`VLEN-1:0]         alu_wr_data;
  logic                     alu_wr_gnt;
  logic                     vrf_wr_en;
  vreg_idx_t                vrf_wr_vd;
  logic [`VLEN-1:0]         vrf_wr_data;

  // Keeps the issue port closed through reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  // Lane k needs k+1 free slots
  always_comb begin
    insts_ready[0] = ready_en & ~cq_full;
    for (int i = 1; i < `ISSUE_LANE; i++) begin
      insts_ready[i] = insts_ready[i-1] & ~cq_almost_full[i-1];
    end
  end

  multi_fifo #(
    .T     (rvv_cmd_t),
    .M     (`ISSUE_LANE),
    .N     (1),
    .DEPTH (`CQ_DEPTH)
  ) u_cmd_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (insts_valid & insts_ready),
    .datain       (insts),
    .pop          (cq_pop),
    .dataout      (cq_head),
    .full         (cq_full),
    .almost_full  (cq_almost_full),
    .empty        (cq_empty),
    .almost_empty ()
  );

  rvv_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cq_head[0]),
    .cq_empty (cq_empty),
    .cq_pop   (cq_pop),
    .uq_full  (uq_full),
    .uq_push  (uq_push),
    .uop      (dec_uop[0])
  );

  multi_fifo #(
    .T     (rvv_uop_t),
    .M     (1),
    .N     (1),
    .DEPTH (`UQ_DEPTH)
  ) u_uop_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (uq_push),
    .datain       (dec_uop),
    .pop          (uq_pop),
    .dataout      (uq_head),
    .full         (uq_full),
    .almost_full  (),
    .empty        (uq_empty),
    .almost_empty ()
  );

  rvv_alu u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop       (uq_head[0]),
    .uq_empty  (uq_empty),
    .uq_pop    (uq_pop),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_req    (alu_wr_req),
    .wr_vd     (alu_wr_vd),
    .wr_data   (alu_wr_data),
    .wr_gnt    (alu_wr_gnt),
    .rt_valid  (rt_valid),
    .rt_vd     (rt_vd),
    .rt_data   (rt_data)
  );

  rvv_vrf_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .alu_req    (alu_wr_req),
    .alu_vd     (alu_wr_vd),
    .alu_data   (alu_wr_data),
    .load_valid (load_valid),
    .load_vd    (load_vd),
    .load_data  (load_data),
    .alu_gnt    (alu_wr_gnt),
    .load_gnt   (load_ready),
    .wr_en      (vrf_wr_en),
    .wr_vd      (vrf_wr_vd),
    .wr_data    (vrf_wr_data)
  );

  rvv_vrf u_vrf (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (vrf_wr_en),
    .wr_vd     (vrf_wr_vd),
    .wr_data   (vrf_wr_data)
  );

endmodule

//--- design/rvv_decode.sv
`timescale 1ns/1ps

module rvv_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvv_isa_pkg::rvv_cmd_t cmd,
  input  logic                  cq_empty,
  output logic                  cq_pop,
  input  logic                  uq_full,
  output logic                  uq_push,
  output rvv_uop_pkg::rvv_uop_t uop
);

  import rvv_isa_pkg::*;
  import rvv_uop_pkg::*;

  logic    dec_en;
  logic    op_ok;
  logic    sew_ok;
  alu_op_e op;

  // Idle until the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_en <= 1'b0;
    end else begin
      dec_en <= 1'b1;
    end
  end

  always_comb begin
    op_ok = 1'b1;
    op    = ALU_ADD;
    case (funct6_e'(cmd.funct6))
      F6_VADD: op = ALU_ADD;
      F6_VSUB: op = ALU_SUB;
      F6_VAND: op = ALU_AND;
      F6_VOR:  op = ALU_OR;
      F6_VXOR: op = ALU_XOR;
      default: op_ok = 1'b0;
    endcase
  end

  always_comb begin
    case (sew_e'(cmd.vsew))
      SEW_E8, SEW_E16, SEW_E32: sew_ok = 1'b1;
      default:                  sew_ok = 1'b0;
    endcase
  end

  // Illegal commands are still popped, they just never reach the uop queue
  assign cq_pop  = dec_en & ~cq_empty & ~uq_full;
  assign uq_push = cq_pop & op_ok & sew_ok;

  assign uop.op  = op;
  assign uop.vs2 = cmd.vs2;
  assign uop.vs1 = cmd.vs1;
  assign uop.vd  = cmd.vd;
  assign uop.sew = cmd.vsew;

endmodule

//--- src.f
+incdir+common
common/rvv_isa_pkg.sv
common/rvv_uop_pkg.sv
design/multi_fifo.sv
design/rvv_decode.sv
design/rvv_alu.sv
vrf/rvv_vrf.sv
vrf/rvv_vrf_arbiter.sv
design/rvv_backend.sv
verification/rvv_backend_props.sv
verification/rvv_backend_tb.sv

//--- verification/rvv_backend_props.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`ISSUE_LANE-1:0] insts_ready,
  input logic                   alu_gnt,
  input logic                   load_gnt,
  input logic                   rt_valid
);

  // Lane 1 only opens together with lane 0
  lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    insts_ready[1] |-> insts_ready[0])
    else $error("insts_ready[1] high while insts_ready[0] low");

  // Single write port
  grant_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_gnt && load_gnt))
    else $error("ALU and load port granted in the same cycle");

  // Back-to-back retires need a grant in the cycle between
  retire_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && $past(rt_valid)) |-> $past(alu_gnt))
    else $error("rt_valid held two cycles without an ALU grant");

endmodule

bind rvv_backend rvv_backend_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .insts_ready (insts_ready),
  .alu_gnt     (alu_wr_gnt),
  .load_gnt    (load_ready),
  .rt_valid    (rt_valid)
);

//--- verification/rvv_backend_tb.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_backend_tb;

  import rvv_isa_pkg::*;

  localparam int NT          = 6;
  localparam int MAX_STEPS   = 48;
  localparam int VL          = `VLEN;
  localparam int CYCLE_LIMIT = 50 * NT + 200;

  logic                       clk;
  logic                       rst_n;
  logic [`ISSUE_LANE-1:0]     insts_valid;
  rvv_cmd_t [`ISSUE_LANE-1:0] insts;
  logic [`ISSUE_LANE-1:0]     insts_ready;
  logic                       load_valid;
  logic [4:0]                 load_vd;
  logic [VL-1:0]              load_data;
  logic                       load_ready;
  logic                       rt_valid;
  logic [4:0]                 rt_vd;
  logic [VL-1:0]              rt_data;

  // Each test row points at its first step row
  // A step is a load or an instruction
  string    test_name [NT];
  int       test_first [NT+1];
  int       test_exp_rt [NT];
  int       test_bg [NT];
  logic     step_load [MAX_STEPS];
  rvv_cmd_t step_cmd [MAX_STEPS];
  int       n_tests;
  int       n_steps;

  logic [VL-1:0] model [`NUM_VREG];
  logic [4:0]    exp_vd_q [$];
  logic [VL-1:0] exp_data_q [$];
  logic [31:0]   rng_state;
  string         cur_name;
  int            err_cnt;
  int            rt_cnt;
  int            cycle_cnt;

  rvv_backend dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .insts_valid (insts_valid),
    .insts       (insts),
    .insts_ready (insts_ready),
    .load_valid  (load_valid),
    .load_vd     (load_vd),
    .load_data   (load_data),
    .load_ready  (load_ready),
    .rt_valid    (rt_valid),
    .rt_vd       (rt_vd),
    .rt_data     (rt_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic legal_cmd(input rvv_cmd_t c);
    logic op_ok;
    op_ok = (c.funct6 == 6'b000000) || (c.funct6 == 6'b000010) ||
            (c.funct6 == 6'b001001) || (c.funct6 == 6'b001010) ||
            (c.funct6 == 6'b001011);
    return op_ok && (c.vsew != 2'd3);
  endfunction

  // Reference result with each element wrapping at its own width
  function automatic logic [VL-1:0] element_op(input logic [5:0] f6, input logic [1:0] sew,
                                               input logic [VL-1:0] a, input logic [VL-1:0] b);
    logic [VL-1:0] res;
    logic [31:0]   ea;
    logic [31:0]   eb;
    logic [31:0]   er;
    logic [31:0]   mask;
    int            w;
    w    = 8 << sew;
    mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
    res  = '0;
    for (int i = 0; i < VL / w; i++) begin
      ea = 32'(a >> (i * w)) & mask;
      eb = 32'(b >> (i * w)) & mask;
      case (f6)
        6'b000000: er = ea + eb;
        6'b000010: er = ea - eb;
        6'b001001: er = ea & eb;
        6'b001010: er = ea | eb;
        default:   er = ea ^ eb;
      endcase
      res = res | (VL'(er & mask) << (i * w));
    end
    return res;
  endfunction

  task automatic add_test(input string name, input int exp_rt, input int bg);
    test_name[n_tests]   = name;
    test_first[n_tests]  = n_steps;
    test_exp_rt[n_tests] = exp_rt;
    test_bg[n_tests]     = bg;
    n_tests++;
  endtask

  task automatic add_inst(input logic [5:0] f6, input logic [1:0] sew, input int vd,
                          input int vs2, input int vs1);
    rvv_cmd_t c;
    c        = '0;
    c.funct6 = f6;
    c.vsew   = sew;
    c.vd     = 5'(vd);
    c.vs2    = 5'(vs2);
    c.vs1    = 5'(vs1);
    step_load[n_steps] = 1'b0;
    step_cmd[n_steps]  = c;
    n_steps++;
  endtask

  task automatic add_load(input int vd);
    rvv_cmd_t c;
    c    = '0;
    c.vd = 5'(vd);
    step_load[n_steps] = 1'b1;
    step_cmd[n_steps]  = c;
    n_steps++;
  endtask

  // Operand order in each row is vd, vs2, vs1
  task automatic build_table();
    add_test("vadd_sew", 3, 0);
    add_load(1);
    add_load(2);
    add_inst(F6_VADD, SEW_E8, 3, 2, 1);
    add_inst(F6_VADD, SEW_E16, 4, 2, 1);
    add_inst(F6_VADD, SEW_E32, 5, 1, 2);
    add_test("sub_logic", 6, 0);
    add_load(6);
    add_load(7);
    add_inst(F6_VSUB, SEW_E8, 8, 6, 7);
    add_inst(F6_VSUB, SEW_E16, 9, 0, 6);
    add_inst(F6_VSUB, SEW_E32, 10, 0, 7);
    add_inst(F6_VAND, SEW_E8, 11, 6, 7);
    add_inst(F6_VOR, SEW_E16, 12, 6, 7);
    add_inst(F6_VXOR, SEW_E32, 13, 6, 7);
    add_test("dep_chain", 5, 0);
    add_load(14);
    add_inst(F6_VADD, SEW_E32, 15, 14, 14);
    add_inst(F6_VADD, SEW_E16, 16, 15, 14);
    add_inst(F6_VSUB, SEW_E8, 17, 16, 15);
    add_inst(F6_VXOR, SEW_E32, 18, 17, 14);
    add_inst(F6_VADD, SEW_E8, 19, 18, 18);
    add_test("burst", 10, 0);
    add_inst(F6_VADD, SEW_E8, 26, 1, 2);
    add_inst(F6_VSUB, SEW_E16, 27, 26, 3);
    add_inst(F6_VXOR, SEW_E32, 28, 27, 4);
    add_inst(F6_VOR, SEW_E8, 29, 5, 28);
    add_inst(F6_VAND, SEW_E16, 30, 29, 6);
    add_inst(F6_VADD, SEW_E32, 31, 30, 7);
    add_inst(F6_VSUB, SEW_E8, 26, 31, 8);
    add_inst(F6_VADD, SEW_E16, 27, 26, 9);
    add_inst(F6_VXOR, SEW_E8, 28, 10, 27);
    add_inst(F6_VSUB, SEW_E32, 29, 28, 11);
    add_test("illegal", 1, 0);
    add_inst(6'b000001, SEW_E8, 20, 1, 2);
    add_inst(F6_VADD, 2'd3, 21, 1, 2);
    add_inst(F6_VOR, SEW_E8, 22, 1, 2);
    // Background loads go to v20..v23, which these instructions never touch
    add_test("load_mix", 7, 8);
    add_inst(F6_VADD, SEW_E8, 14, 1, 2);
    add_inst(F6_VSUB, SEW_E16, 15, 3, 4);
    add_inst(F6_VXOR, SEW_E32, 16, 14, 15);
    add_inst(F6_VAND, SEW_E8, 17, 5, 6);
    add_inst(F6_VADD, SEW_E32, 18, 16, 17);
    add_inst(F6_VOR, SEW_E16, 19, 7, 8);
    add_load(24);
    add_inst(F6_VOR, SEW_E32, 25, 24, 0);
    test_first[n_tests] = n_steps;
  endtask

  task automatic predict(input rvv_cmd_t c);
    logic [VL-1:0] res;
    if (legal_cmd(c)) begin
      res = element_op(c.funct6, c.vsew, model[c.vs2], model[c.vs1]);
      model[c.vd] = res;
      exp_vd_q.push_back(c.vd);
      exp_data_q.push_back(res);
    end
  endtask

  // Starts right after a rising edge and returns on the edge that takes the load
  task automatic send_load(input logic [4:0] vd);
    logic [VL-1:0] data;
    for (int i = 0; i < VL / 32; i++) begin
      data[i*32 +: 32] = next_rand();
    end
    load_valid <= 1'b1;
    load_vd    <= vd;
    load_data  <= data;
    @(negedge clk);
    while (!load_ready) begin
      @(negedge clk);
    end
    model[vd] = data;
    @(posedge clk);
  endtask

  task automatic stream_loads(input int n);
    @(posedge clk);
    for (int i = 0; i < n; i++) begin
      send_load(5'(20 + i % 4));
    end
    load_valid <= 1'b0;
  endtask

  // Oldest command goes on lane 0 and ready is sampled mid-cycle
  task automatic issue_cmds(input int first, input int last);
    int idx;
    int take;
    idx = first;
    @(posedge clk);
    while (idx < last) begin
      insts_valid <= (idx + 1 < last) ? 2'b11 : 2'b01;
      insts[0]    <= step_cmd[idx];
      if (idx + 1 < last) begin
        insts[1] <= step_cmd[idx+1];
      end
      @(negedge clk);
      take = 0;
      if (insts_ready[0]) begin
        take = (insts_valid[1] && insts_ready[1]) ? 2 : 1;
      end
      for (int k = 0; k < take; k++) begin
        predict(step_cmd[idx+k]);
      end
      idx = idx + take;
      @(posedge clk);
    end
    insts_valid <= '0;
  endtask

  always @(negedge clk) begin : check_retire
    logic [4:0]    ev;
    logic [VL-1:0] ed;
    if (rst_n && rt_valid) begin
      rt_cnt++;
      if (exp_vd_q.size() == 0) begin
        $display("Unexpected retire of v%0d in test %s", rt_vd, cur_name);
        err_cnt++;
      end else begin
        ev = exp_vd_q.pop_front();
        ed = exp_data_q.pop_front();
        if (rt_vd !== ev) begin
          $display("Fail %s: rt_vd expected %0d actual %0d", cur_name, ev, rt_vd);
          err_cnt++;
        end
        if (rt_data !== ed) begin
          $display("Fail %s: rt_data expected %h actual %h", cur_name, ed, rt_data);
          err_cnt++;
        end
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: retire never arrived");
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    int errs_before;
    int rt_before;
    int pass_cnt;
    int idx;
    int run;
    int last;
    rst_n       = 1'b0;
    insts_valid = '0;
    insts       = '0;
    load_valid  = 1'b0;
    load_vd     = '0;
    load_data   = '0;
    err_cnt     = 0;
    rt_cnt      = 0;
    n_tests     = 0;
    n_steps     = 0;
    pass_cnt    = 0;
    rng_state   = 32'h1ba9;
    cur_name    = "reset";
    for (int r = 0; r < `NUM_VREG; r++) begin
      model[r] = '0;
    end
    build_table();
    // Outputs during reset
    @(negedge clk);
    if (insts_ready !== '0) begin
      $display("Fail %s: insts_ready expected %b actual %b", cur_name,
               {`ISSUE_LANE{1'b0}}, insts_ready);
      err_cnt++;
    end
    if (load_ready !== 1'b0) begin
      $display("Fail %s: load_ready expected 0 actual %b", cur_name, load_ready);
      err_cnt++;
    end
    if (rt_valid !== 1'b0) begin
      $display("Fail %s: rt_valid expected 0 actual %b", cur_name, rt_valid);
      err_cnt++;
    end
    @(posedge clk);
    rst_n <= 1'b1;
    // Issue port opens once the first edge out of reset has passed
    @(posedge clk);
    @(negedge clk);
    if (insts_ready !== {`ISSUE_LANE{1'b1}}) begin
      $display("Fail %s: insts_ready expected %b actual %b", cur_name,
               {`ISSUE_LANE{1'b1}}, insts_ready);
      err_cnt++;
    end
    for (int t = 0; t < NT; t++) begin
      cur_name    = test_name[t];
      errs_before = err_cnt;
      rt_before   = rt_cnt;
      idx         = test_first[t];
      last        = test_first[t+1];
      while (idx < last) begin
        if (step_load[idx]) begin
          @(posedge clk);
          send_load(step_cmd[idx].vd);
          load_valid <= 1'b0;
          idx++;
        end else begin
          run = idx;
          while (run < last && !step_load[run]) begin
            run++;
          end
          if (test_bg[t] > 0) begin
            fork
              issue_cmds(idx, run);
              stream_loads(test_bg[t]);
            join
          end else begin
            issue_cmds(idx, run);
          end
          idx = run;
        end
      end
      while (exp_vd_q.size() != 0) begin
        @(negedge clk);
      end
      // A few idle cycles to catch stray retires
      repeat (4) @(negedge clk);
      if (rt_cnt - rt_before != test_exp_rt[t]) begin
        $display("Fail %s: retire count expected %0d actual %0d", cur_name,
                 test_exp_rt[t], rt_cnt - rt_before);
        err_cnt++;
      end
      if (err_cnt == errs_before) begin
        pass_cnt++;
        $display("Test %s ok, %0d retires", cur_name, rt_cnt - rt_before);
      end else begin
        $display("Test %s failed with %0d errors", cur_name, err_cnt - errs_before);
      end
    end
    $display("Summary: %0d tests, %0d ok, %0d failed, %0d check errors", NT, pass_cnt,
             NT - pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- vrf/rvv_vrf.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_vrf (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rvv_uop_pkg::vreg_idx_t rd_idx_a,
  input  rvv_uop_pkg::vreg_idx_t rd_idx_b,
  output logic [`VLEN-1:0]       rd_data_a,
  output logic [`VLEN-1:0]       rd_data_b,
  input  logic                   wr_en,
  input  rvv_uop_pkg::vreg_idx_t wr_vd,
  input  logic [`VLEN-1:0]       wr_data
);

  import rvv_uop_pkg::*;

  logic [`VLEN-1:0] vreg [`NUM_VREG];

  // Architectural state starts at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_VREG; i++) begin
        vreg[i] <= '0;
      end
    end else if (wr_en) begin
      vreg[wr_vd] <= wr_data;
    end
  end

  // No bypass, a write is visible from the next cycle
  assign rd_data_a = vreg[rd_idx_a];
  assign rd_data_b = vreg[rd_idx_b];

endmodule

//--- vrf/rvv_vrf_arbiter.sv
`timescale 1ns/1ps
`include "rvv_config.svh"

module rvv_vrf_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   alu_req,
  input  rvv_uop_pkg::vreg_idx_t alu_vd,
  input  logic [`VLEN-1:0]       alu_data,
  input  logic                   load_valid,
  input  rvv_uop_pkg::vreg_idx_t load_vd,
  input  logic [`VLEN-1:0]       load_data,
  output logic                   alu_gnt,
  output logic                   load_gnt,
  output logic                   wr_en,
  output rvv_uop_pkg::vreg_idx_t wr_vd,
  output logic [`VLEN-1:0]       wr_data
);

  import rvv_uop_pkg::*;

  // Set when the load port took the last grant
  logic last_load;

  assign load_gnt = load_valid & (~alu_req | ~last_load);
  assign alu_gnt  = alu_req & (~load_valid | last_load);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_load <= 1'b0;
    end else if (load_gnt) begin
      last_load <= 1'b1;
    end else if (alu_gnt) begin
      last_load <= 1'b0;
    end
  end

  assign wr_en   = alu_gnt | load_gnt;
  assign wr_vd   = load_gnt ? load_vd : alu_vd;
  assign wr_data = load_gnt ? load_data : alu_data;

endmodule
